// ==== Makefile ====
# Verilator flow for the SDRAM subsystem

VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= tb_sdram
RTL_TOP   ?= sdram_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)

// ==== compile.f ====
src/sdram_pkg.sv
src/sdram_timer.sv
src/sdram_controller.sv
src/sdram_top.sv
dv/sdram_model.sv
dv/sdram_assertions.sv
dv/tb_sdram.sv

// ==== dv/sdram_assertions.sv ====
//****************************************
// SDRAM controller command checks
// Command spacing, t_rcd and completion
// pulse width on the controller pins
//****************************************

module sdram_assertions (
    input logic clk,
    input logic reset,
    input logic s_cs_n,
    input logic s_ras_n,
    input logic s_cas_n,
    input logic s_wr_en,
    input logic h_compl
);

    import sdram_pkg::*;

    sdram_cmd_e cmd;
    logic is_nop;
    logic is_act;
    logic is_col;
    logic in_access;
    int   since_act;
    int   fail_count = 0;

    assign cmd = sdram_cmd_e'({s_cs_n, s_ras_n, s_cas_n, s_wr_en});
    assign is_nop = cmd == cmd_nop;
    assign is_act = cmd == cmd_act;
    assign is_col = cmd == cmd_read || cmd == cmd_write;

    // open from the activate until the access completes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            in_access <= 1'b0;
            since_act <= 0;
        end else begin
            since_act <= is_act ? 1 : since_act + 1;
            if (is_act) in_access <= 1'b1;
            else if (h_compl) in_access <= 1'b0;
        end
    end

    one_cmd_per_cycle: assert property (@(posedge clk) disable iff (reset)
        !is_nop |=> is_nop)
        else begin
            $error("command held longer than one cycle");
            fail_count++;
        end

    act_to_col: assert property (@(posedge clk) disable iff (reset)
        is_col |-> since_act >= t_rcd)
        else begin
            $error("read or write issued before t_rcd");
            fail_count++;
        end

    compl_single: assert property (@(posedge clk) disable iff (reset)
        h_compl |=> !h_compl)
        else begin
            $error("completion pulse wider than one cycle");
            fail_count++;
        end

    no_foreign_cmd: assert property (@(posedge clk) disable iff (reset)
        in_access && !h_compl |-> is_nop || is_col)
        else begin
            $error("foreign command inside an access");
            fail_count++;
        end

endmodule

bind sdram_controller sdram_assertions u_assertions (
    .clk     (clk),
    .reset   (reset),
    .s_cs_n  (s_cs_n),
    .s_ras_n (s_ras_n),
    .s_cas_n (s_cas_n),
    .s_wr_en (s_wr_en),
    .h_compl (h_compl)
);

// ==== dv/sdram_model.sv ====
//****************************************
// Behavioral SDR SDRAM model
// Decodes commands, stores words under
// the byte mask, returns read data after
// CAS latency 2, counts protocol errors
//****************************************

module sdram_model (
    input  logic                   clk,
    input  logic                   cs_n,
    input  logic                   ras_n,
    input  logic                   cas_n,
    input  logic                   we_n,
    input  sdram_pkg::byte_sel_t   dqm,
    input  sdram_pkg::sdram_addr_t addr,
    input  sdram_pkg::bank_sel_t   ba,
    inout  wire sdram_pkg::host_data_t dq
);

    import sdram_pkg::*;

    // key is {bank, row, column}
    host_data_t mem [logic [24:0]];

    int error_count = 0;
    int ref_count = 0;
    // 0 waits for precharge-all, 1 and 2 for refreshes, 3 for the mode set
    int init_stage = 0;

    logic [3:0]  bank_open = '0;
    sdram_addr_t open_row [4];
    int          act_age [4];

    logic       rd_pending = 1'b0;
    logic       dq_valid = 1'b0;
    host_data_t rd_word = '0;
    host_data_t dq_out = '0;

    sdram_cmd_e cmd;
    logic [24:0] key;
    host_data_t word;

    assign cmd = sdram_cmd_e'({cs_n, ras_n, cas_n, we_n});
    assign dq = dq_valid ? dq_out : 'z;
    assign key = {ba, open_row[ba], addr[9:0]};

    task automatic protocol_error(input string what);
        $display("ERROR: sdram model at %0t: %s", $time, what);
        error_count++;
    endtask

    always @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            act_age[b] = act_age[b] + 1;
        end
        // two-stage pipe gives the read word on the bus CAS latency later
        dq_valid <= rd_pending;
        dq_out <= rd_word;
        rd_pending <= 1'b0;
        case (cmd)
            cmd_pre: begin
                if (init_stage == 0 && addr[10]) init_stage = 1;
                if (addr[10]) bank_open = '0;
                else bank_open[ba] = 1'b0;
            end
            cmd_ref: begin
                if (bank_open != 0) protocol_error("refresh with a bank open");
                if (init_stage == 1 || init_stage == 2) init_stage++;
                else if (init_stage < 4) protocol_error("refresh out of init order");
                ref_count++;
            end
            cmd_mrs: begin
                if (init_stage != 3) protocol_error("mode set out of init order");
                if (addr[2:0] != 3'b001 || addr[6:4] != 3'd2) begin
                    protocol_error("mode word is not burst 2, CAS 2");
                end
                init_stage = 4;
            end
            cmd_act: begin
                if (init_stage != 4) protocol_error("activate before init finished");
                if (bank_open[ba]) protocol_error("activate to an open bank");
                bank_open[ba] = 1'b1;
                open_row[ba] = addr;
                act_age[ba] = 0;
            end
            cmd_read, cmd_write: begin
                if (!bank_open[ba]) protocol_error("column command to a closed bank");
                if (act_age[ba] < t_rcd) protocol_error("column command before t_rcd");
                if (cmd == cmd_write) begin
                    word = mem.exists(key) ? mem[key] : '0;
                    if (!dqm[0]) word[7:0] = dq[7:0];
                    if (!dqm[1]) word[15:8] = dq[15:8];
                    mem[key] = word;
                end else begin
                    rd_word <= mem.exists(key) ? mem[key] : '0;
                    rd_pending <= 1'b1;
                end
                if (addr[10]) bank_open[ba] = 1'b0;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== dv/tb_sdram.sv ====
//****************************************
// SDRAM subsystem testbench
// Drives host accesses into the top level
// and checks them against a reference
// memory and a behavioral SDRAM model
//****************************************

module tb_sdram;

    import sdram_pkg::*;

    localparam int config_timeout = 4000;
    localparam int access_timeout = 100;
    localparam int refresh_clks = 195;

    logic clk = 1'b0;
    logic reset;
    logic cs;
    logic data_m_access;
    host_addr_t h_addr;
    host_data_t h_wdata;
    logic h_wr_en;
    byte_sel_t h_bytesel;
    host_data_t h_rdata;
    logic h_compl;
    logic h_config_done;
    logic s_ras_n, s_cas_n, s_wr_en, s_cs_n, s_clken;
    byte_sel_t s_bytesel;
    sdram_addr_t s_addr;
    bank_sel_t s_banksel;
    wire host_data_t s_data;

    int errors = 0;
    int assert_errors;
    int n;
    int refs_before;
    int cycle_count = 0;
    int start_cycle;
    logic [31:0] rng = 32'h6105;
    host_addr_t addr_q [$];
    host_data_t ref_mem [host_addr_t];
    host_data_t exp_data;
    logic exp_wr;
    logic req_active = 1'b0;
    logic compl_seen = 1'b0;

    sdram_top UUT (
        .clk (clk), .reset (reset), .cs (cs), .data_m_access (data_m_access),
        .h_addr (h_addr), .h_wdata (h_wdata), .h_wr_en (h_wr_en),
        .h_bytesel (h_bytesel), .h_rdata (h_rdata), .h_compl (h_compl),
        .h_config_done (h_config_done), .s_ras_n (s_ras_n), .s_cas_n (s_cas_n),
        .s_wr_en (s_wr_en), .s_cs_n (s_cs_n), .s_clken (s_clken),
        .s_bytesel (s_bytesel), .s_addr (s_addr), .s_banksel (s_banksel),
        .s_data (s_data)
    );

    sdram_model u_model (
        .clk (clk), .cs_n (s_cs_n), .ras_n (s_ras_n), .cas_n (s_cas_n),
        .we_n (s_wr_en), .dqm (s_bytesel), .addr (s_addr), .ba (s_banksel),
        .dq (s_data)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // applies a write under its byte select and returns the word now stored
    function automatic host_data_t ref_access(input host_addr_t a, input host_data_t d,
                                              input logic wr, input byte_sel_t bs);
        host_data_t w;
        w = ref_mem.exists(a) ? ref_mem[a] : '0;
        if (wr) begin
            if (bs[0]) w[7:0] = d[7:0];
            if (bs[1]) w[15:8] = d[15:8];
            ref_mem[a] = w;
        end
        return w;
    endfunction

    task automatic host_access(input host_addr_t a, input host_data_t d,
                               input logic wr, input byte_sel_t bs);
        int cnt;
        @(posedge clk);
        #1;
        exp_data = ref_access(a, d, wr, bs);
        exp_wr = wr;
        compl_seen = 1'b0;
        req_active = 1'b1;
        cs = 1'b1;
        data_m_access = 1'b1;
        h_addr = a;
        h_wdata = d;
        h_wr_en = wr;
        h_bytesel = bs;
        cnt = 0;
        while (!compl_seen && cnt < access_timeout) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!compl_seen) begin
            $display("ERROR: access to %h timed out at %0t", a, $time);
            errors++;
            req_active = 1'b0;
        end
        cs = 1'b0;
        data_m_access = 1'b0;
    endtask

    task automatic random_access(input logic wr);
        host_addr_t a;
        rng = xorshift(rng);
        a = {1'b0, rng[23:0]};
        // every second write lands one address bit away from the previous one so that
        // a bank, row or column bit dropped by the mapping makes the two collide
        if (wr && addr_q.size() % 2 == 1) begin
            a = addr_q[$] ^ (25'h1 << ((addr_q.size() / 2) % 24));
        end
        rng = xorshift(rng);
        host_access(a, rng[15:0], wr, wr ? rng[17:16] | 2'b01 : 2'b11);
        if (wr) addr_q.push_back(a);
    endtask

    // outputs are sampled on the falling edge, well away from both updates
    always @(negedge clk) begin
        if (!reset) begin
            if (s_clken !== 1'b1) begin
                $display("MISMATCH at %0t: s_clken got %b expected %b", $time, s_clken, 1'b1);
                errors++;
            end
            if (!h_compl && h_rdata !== '0) begin
                $display("MISMATCH at %0t: h_rdata got %h expected %h", $time, h_rdata, 16'h0);
                errors++;
            end
            if (h_compl && !req_active) begin
                $display("ERROR: h_compl without a request at %0t", $time);
                errors++;
            end else if (h_compl) begin
                if (!exp_wr && h_rdata !== exp_data) begin
                    $display("MISMATCH at %0t: h_rdata got %h expected %h",
                             $time, h_rdata, exp_data);
                    errors++;
                end
                req_active = 1'b0;
                compl_seen = 1'b1;
            end
        end
    end

    initial begin
        reset = 1'b1;
        cs = 1'b0;
        data_m_access = 1'b0;
        h_addr = '0;
        h_wdata = '0;
        h_wr_en = 1'b0;
        h_bytesel = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        n = 0;
        while (!h_config_done && n < config_timeout) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!h_config_done) begin
            $display("ERROR: h_config_done did not rise after reset");
            errors++;
        end
        if (u_model.init_stage != 4) begin
            $display("ERROR: init sequence incomplete, stage %0d", u_model.init_stage);
            errors++;
        end

        host_access(25'h0123456, 16'ha5c3, 1'b1, 2'b11);
        host_access(25'h0123456, 16'h0000, 1'b0, 2'b11);

        host_access(25'h1abcdef, 16'h1234, 1'b1, 2'b11);
        host_access(25'h1abcdef, 16'hff77, 1'b1, 2'b01);
        host_access(25'h1abcdef, 16'h88ff, 1'b1, 2'b10);
        host_access(25'h1abcdef, 16'h0000, 1'b0, 2'b11);

        repeat (100) random_access(1'b1);
        while (addr_q.size() > 0) begin
            host_access(addr_q.pop_back(), 16'h0000, 1'b0, 2'b11);
        end

        refs_before = u_model.ref_count;
        repeat (10 * refresh_clks) @(posedge clk);
        if (u_model.ref_count - refs_before < 9) begin
            $display("ERROR: only %0d refreshes over 10 intervals",
                     u_model.ref_count - refs_before);
            errors++;
        end

        // back-to-back traffic over the same span still has to let refresh in
        refs_before = u_model.ref_count;
        start_cycle = cycle_count;
        while (cycle_count - start_cycle < 10 * refresh_clks) begin
            random_access(1'b1);
            host_access(addr_q.pop_back(), 16'h0000, 1'b0, 2'b11);
        end
        if (u_model.ref_count - refs_before < 9) begin
            $display("ERROR: only %0d refreshes over 10 intervals of traffic",
                     u_model.ref_count - refs_before);
            errors++;
        end

        assert_errors = UUT.u_controller.u_assertions.fail_count;
        $display("errors: %0d check, %0d protocol, %0d assertion",
                 errors, u_model.error_count, assert_errors);
        if (errors == 0 && u_model.error_count == 0 && assert_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== src/sdram_controller.sv ====
//****************************************
// SDR SDRAM controller
// Runs the power-up sequence, then turns
// each host access into an activate and
// a read or write with auto-precharge,
// inserting auto-refresh as needed
//****************************************

module sdram_controller #(
    parameter int unsigned mem_size_bytes = 32 * 1024 * 1024,
    parameter int unsigned clk_freq_hz = 25000000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cs,
    input  logic                    data_m_access,
    input  sdram_pkg::host_addr_t   h_addr,
    input  sdram_pkg::host_data_t   h_wdata,
    input  logic                    h_wr_en,
    input  sdram_pkg::byte_sel_t    h_bytesel,
    output sdram_pkg::host_data_t   h_rdata,
    output logic                    h_compl,
    output logic                    h_config_done,
    output logic                    s_ras_n,
    output logic                    s_cas_n,
    output logic                    s_wr_en,
    output logic                    s_cs_n,
    output logic                    s_clken,
    output sdram_pkg::byte_sel_t    s_bytesel,
    output sdram_pkg::sdram_addr_t  s_addr,
    output sdram_pkg::bank_sel_t    s_banksel,
    inout  wire sdram_pkg::host_data_t s_data
);

    import sdram_pkg::*;

    localparam int ns_per_clk = 1000000000 / clk_freq_hz;

    // 100 us of settling time after power-up
    localparam int reset_wait_clks = 100000 / ns_per_clk;

    // 8192 refreshes every 64 ms
    localparam int refresh_clks = ((64 * 1000000) / ns_per_clk) / 8192;

    // longest path from idle back to idle for a host access, a refresh has
    // to be requested this early so that an access in flight can finish
    localparam int max_cmd_period = t_rcd + t_rp + 1;
    localparam int refresh_max = refresh_clks - max_cmd_period;

    localparam int timec_width = $clog2(reset_wait_clks + 1);
    localparam int refc_width = $clog2(refresh_max + 1);

    // last count of each timed state
    localparam logic [timec_width-1:0] tc_reset_end = timec_width'(reset_wait_clks - 1);
    localparam logic [timec_width-1:0] tc_rp_end = timec_width'(t_rp - 1);
    localparam logic [timec_width-1:0] tc_rc_end = timec_width'(t_rc - 1);
    localparam logic [timec_width-1:0] tc_mrd_end = timec_width'(t_mrd - 1);
    localparam logic [timec_width-1:0] tc_rcd_end = timec_width'(t_rcd - 1);
    localparam logic [timec_width-1:0] tc_read_end = timec_width'(cas_latency);
    localparam logic [timec_width-1:0] tc_write_end = timec_width'(t_rp);
    localparam logic [refc_width-1:0] refresh_limit = refc_width'(refresh_max);

    // mode register: single-location writes, sequential burst of 2
    localparam sdram_addr_t mode_word = {3'b000, 1'b1, 2'b00, 3'(cas_latency), 1'b0, 3'b001};

    // precharge-all is a precharge with A10 set
    localparam sdram_addr_t pre_all_addr = sdram_addr_t'(1 << 10);

    typedef enum logic [3:0] {
        st_reset_wait,
        st_reset_pch,
        st_reset_ref1,
        st_reset_ref2,
        st_mrs,
        st_idle,
        st_act,
        st_read,
        st_write,
        st_autoref
    } state_e;

    state_e state;
    state_e next_state;

    sdram_cmd_e cmd;
    host_data_t out_data;
    byte_sel_t out_mask;
    logic oe;

    bank_sel_t acc_bank;
    sdram_addr_t acc_row;
    sdram_addr_t acc_col;

    logic [timec_width-1:0] timec;
    logic state_clr;
    logic [refc_width-1:0] refresh_count;
    logic refresh_clr;
    logic refresh_pending;
    logic read_done;
    logic write_done;

    assign {s_cs_n, s_ras_n, s_cas_n, s_wr_en} = cmd;
    assign s_data = oe ? out_data : 'z;
    assign s_bytesel = out_mask;
    assign s_clken = 1'b1;

    // banks are laid out one after the other, so bank comes from the top
    // address bits and consecutive words stay in one row
    generate
        if (mem_size_bytes == 32 * 1024 * 1024) begin : g_map_32mb
            assign acc_bank = h_addr[24:23];
            assign acc_row = h_addr[22:10];
            assign acc_col = {2'b00, 1'b1, 1'b0, h_addr[9:1]};
        end else begin : g_map_64mb
            // 64 MB part with 1024 columns per row
            assign acc_bank = h_addr[25:24];
            assign acc_row = h_addr[23:11];
            assign acc_col = {2'b00, 1'b1, h_addr[10:1]};
        end
    endgenerate

    // the state timer restarts from zero in the first cycle of every state
    assign state_clr = reset | (state != next_state);

    sdram_timer #(
        .count_width (timec_width),
        .count_max   (reset_wait_clks)
    ) u_state_timer (
        .clk   (clk),
        .reset (state_clr),
        .count (timec)
    );

    assign refresh_clr = reset | (state == st_autoref && timec == tc_rc_end);

    sdram_timer #(
        .count_width (refc_width),
        .count_max   (refresh_max)
    ) u_refresh_timer (
        .clk   (clk),
        .reset (refresh_clr),
        .count (refresh_count)
    );

    assign refresh_pending = refresh_count == refresh_limit;

    assign read_done = state == st_read && timec == tc_read_end;
    assign write_done = state == st_write && timec == tc_write_end;

    always_comb begin
        next_state = state;
        case (state)
            st_reset_wait: begin
                if (timec == tc_reset_end) begin
                    next_state = st_reset_pch;
                end
            end
            st_reset_pch: begin
                if (timec == tc_rp_end) begin
                    next_state = st_reset_ref1;
                end
            end
            st_reset_ref1: begin
                if (timec == tc_rc_end) begin
                    next_state = st_reset_ref2;
                end
            end
            st_reset_ref2: begin
                if (timec == tc_rc_end) begin
                    next_state = st_mrs;
                end
            end
            st_mrs: begin
                if (timec == tc_mrd_end) begin
                    next_state = st_idle;
                end
            end
            st_idle: begin
                // h_compl is high in the first idle cycle after an access,
                // while the host still shows the request it just finished
                if (!h_compl && refresh_pending) begin
                    next_state = st_autoref;
                end else if (!h_compl && cs && data_m_access) begin
                    next_state = st_act;
                end
            end
            st_act: begin
                if (timec == tc_rcd_end) begin
                    next_state = h_wr_en ? st_write : st_read;
                end
            end
            st_read: begin
                if (read_done) begin
                    next_state = st_idle;
                end
            end
            st_write: begin
                // leave room for the auto-precharge to finish
                if (write_done) begin
                    next_state = st_idle;
                end
            end
            st_autoref: begin
                if (timec == tc_rc_end) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_reset_wait;
        end else begin
            state <= next_state;
        end
    end

    // a command goes out for one cycle on entry to a state, nop otherwise
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd <= cmd_nop;
            s_addr <= '0;
            s_banksel <= '0;
            oe <= 1'b0;
        end else begin
            cmd <= cmd_nop;
            s_addr <= '0;
            s_banksel <= '0;
            if (state != next_state) begin
                case (next_state)
                    st_reset_pch: begin
                        cmd <= cmd_pre;
                        s_addr <= pre_all_addr;
                        s_banksel <= 2'b11;
                    end
                    st_reset_ref1, st_reset_ref2, st_autoref: begin
                        cmd <= cmd_ref;
                    end
                    st_mrs: begin
                        cmd <= cmd_mrs;
                        s_addr <= mode_word;
                    end
                    st_act: begin
                        cmd <= cmd_act;
                        s_addr <= acc_row;
                        s_banksel <= acc_bank;
                    end
                    st_read: begin
                        cmd <= cmd_read;
                        s_addr <= acc_col;
                        s_banksel <= acc_bank;
                    end
                    st_write: begin
                        cmd <= cmd_write;
                        s_addr <= acc_col;
                        s_banksel <= acc_bank;
                        oe <= 1'b1;
                    end
                    st_idle: begin
                        oe <= 1'b0;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // write data is taken while idle, the host holds it until completion
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            out_data <= h_wdata;
        end
    end

    // DQM is active low of the host byte select, reads leave both bytes on
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_mask <= '0;
        end else if (state == st_idle) begin
            out_mask <= h_wr_en ? ~h_bytesel : 2'b00;
        end
    end

    // first read word is on the bus in the last cycle of the read state
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_rdata <= '0;
        end else begin
            h_rdata <= read_done ? s_data : '0;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_compl <= 1'b0;
        end else begin
            h_compl <= read_done | write_done;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_config_done <= 1'b0;
        end else if (state == st_idle) begin
            h_config_done <= 1'b1;
        end
    end

endmodule

// ==== src/sdram_pkg.sv ====
//****************************************
// SDRAM controller shared definitions
// Width types for the host and device
// buses, the SDRAM command truth table
// and the fixed device timing in clocks
//****************************************

package sdram_pkg;

    // host word address, byte address bit 0 is never used
    typedef logic [25:1] host_addr_t;
    typedef logic [15:0] host_data_t;
    typedef logic [1:0]  byte_sel_t;

    // device row, column and mode-register address bus
    typedef logic [12:0] sdram_addr_t;
    typedef logic [1:0]  bank_sel_t;

    // each code is {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        cmd_mrs   = 4'b0000,
        cmd_ref   = 4'b0001,
        cmd_pre   = 4'b0010,
        cmd_act   = 4'b0011,
        cmd_write = 4'b0100,
        cmd_read  = 4'b0101,
        cmd_bst   = 4'b0110,
        cmd_nop   = 4'b0111
    } sdram_cmd_e;

    // refresh cycle time, also the gap between the two init refreshes
    localparam int t_rc = 8;

    // precharge time
    localparam int t_rp = 2;

    // mode-register set to the first following command
    localparam int t_mrd = 2;

    // activate to read or write
    localparam int t_rcd = 2;

    // read command to first data word
    localparam int cas_latency = 2;

endpackage

// ==== src/sdram_timer.sv ====
//****************************************
// SDRAM cycle timer
// Counts clocks up from zero and holds
// at a fixed maximum until cleared
//****************************************

module sdram_timer #(
    parameter int count_width = 8,
    parameter int count_max = 255
) (
    input  logic                   clk,
    input  logic                   reset,
    output logic [count_width-1:0] count
);

    localparam logic [count_width-1:0] count_limit = count_width'(count_max);

    // the clear is taken on the clock edge, so the parent can drive it from
    // its next-state logic and see a zero count in the first cycle of a state
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (count != count_limit) begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== src/sdram_top.sv ====
//****************************************
// SDRAM subsystem top level
// Sets the device size and clock rate
// and ties the controller to the host
// ports and the SDRAM pins
//****************************************

module sdram_top #(
    parameter int unsigned mem_size_bytes = 32 * 1024 * 1024,
    parameter int unsigned clk_freq_hz = 25000000
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cs,
    input  logic                    data_m_access,
    input  sdram_pkg::host_addr_t   h_addr,
    input  sdram_pkg::host_data_t   h_wdata,
    input  logic                    h_wr_en,
    input  sdram_pkg::byte_sel_t    h_bytesel,
    output sdram_pkg::host_data_t   h_rdata,
    output logic                    h_compl,
    output logic                    h_config_done,
    output logic                    s_ras_n,
    output logic                    s_cas_n,
    output logic                    s_wr_en,
    output logic                    s_cs_n,
    output logic                    s_clken,
    output sdram_pkg::byte_sel_t    s_bytesel,
    output sdram_pkg::sdram_addr_t  s_addr,
    output sdram_pkg::bank_sel_t    s_banksel,
    inout  wire sdram_pkg::host_data_t s_data
);

    // single controller driving one x16 device
    sdram_controller #(
        .mem_size_bytes (mem_size_bytes),
        .clk_freq_hz    (clk_freq_hz)
    ) u_controller (
        .clk           (clk),
        .reset         (reset),
        .cs            (cs),
        .data_m_access (data_m_access),
        .h_addr        (h_addr),
        .h_wdata       (h_wdata),
        .h_wr_en       (h_wr_en),
        .h_bytesel     (h_bytesel),
        .h_rdata       (h_rdata),
        .h_compl       (h_compl),
        .h_config_done (h_config_done),
        .s_ras_n       (s_ras_n),
        .s_cas_n       (s_cas_n),
        .s_wr_en       (s_wr_en),
        .s_cs_n        (s_cs_n),
        .s_clken       (s_clken),
        .s_bytesel     (s_bytesel),
        .s_addr        (s_addr),
        .s_banksel     (s_banksel),
        .s_data        (s_data)
    );

endmodule
